// File: flist.f
logic/dtim_pkg.sv
logic/dtim_array.sv
logic/dtim_ctrl.sv
logic/dtim.sv
verification/dtim_properties.sv
verification/tb_dtim.sv

// File: logic/dtim.sv
`default_nettype none

module dtim
  import dtim_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        req_valid,
  input  logic        req_fence,
  input  logic [31:0] req_addr,
  input  logic [31:0] req_wdata,
  input  logic [3:0]  req_wstrb,
  output logic        rsp_ready,
  output logic [31:0] rsp_rdata,
  output logic        mem_valid,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  output logic [3:0]  mem_wstrb,
  input  logic        mem_ready,
  input  logic [31:0] mem_rdata
);

  logic   tag_wen;
  logic   data_wen;
  logic   lock_wen;
  index_t line_waddr;
  index_t line_raddr;
  tag_t   tag_wdata;
  tag_t   tag_rdata;
  line_t  data_wdata;
  line_t  data_rdata;
  lock_t  lock_wdata;
  lock_t  lock_rdata;

  dtim_ctrl ctrl (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_fence  (req_fence),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_wstrb  (req_wstrb),
    .rsp_ready  (rsp_ready),
    .rsp_rdata  (rsp_rdata),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata),
    .tag_wen    (tag_wen),
    .data_wen   (data_wen),
    .lock_wen   (lock_wen),
    .line_waddr (line_waddr),
    .line_raddr (line_raddr),
    .tag_wdata  (tag_wdata),
    .tag_rdata  (tag_rdata),
    .data_wdata (data_wdata),
    .data_rdata (data_rdata),
    .lock_wdata (lock_wdata),
    .lock_rdata (lock_rdata)
  );

  // All three arrays share the same read and write index.
  dtim_array #(.payload_t(tag_t)) tag_store (
    .clk   (clk),
    .wen   (tag_wen),
    .waddr (line_waddr),
    .wdata (tag_wdata),
    .raddr (line_raddr),
    .rdata (tag_rdata)
  );

  dtim_array #(.payload_t(line_t)) line_store (
    .clk   (clk),
    .wen   (data_wen),
    .waddr (line_waddr),
    .wdata (data_wdata),
    .raddr (line_raddr),
    .rdata (data_rdata)
  );

  dtim_array #(.payload_t(lock_t)) lock_store (
    .clk   (clk),
    .wen   (lock_wen),
    .waddr (line_waddr),
    .wdata (lock_wdata),
    .raddr (line_raddr),
    .rdata (lock_rdata)
  );

endmodule

`default_nettype wire

// File: logic/dtim_array.sv
`default_nettype none

module dtim_array
  import dtim_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     wen,
  input  index_t   waddr,
  input  payload_t wdata,
  input  index_t   raddr,
  output payload_t rdata
);

  // One entry per line index. Contents are zero at power up.
  payload_t mem [0:2**line_depth-1] = '{default: '0};

  // A read returns the value from before a write to the same entry in the same cycle.
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// File: logic/dtim_ctrl.sv
`default_nettype none

module dtim_ctrl
  import dtim_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        req_valid,
  input  logic        req_fence,
  input  logic [31:0] req_addr,
  input  logic [31:0] req_wdata,
  input  logic [3:0]  req_wstrb,
  output logic        rsp_ready,
  output logic [31:0] rsp_rdata,
  output logic        mem_valid,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  output logic [3:0]  mem_wstrb,
  input  logic        mem_ready,
  input  logic [31:0] mem_rdata,
  output logic        tag_wen,
  output logic        data_wen,
  output logic        lock_wen,
  output index_t      line_waddr,
  output index_t      line_raddr,
  output tag_t        tag_wdata,
  input  tag_t        tag_rdata,
  output line_t       data_wdata,
  input  line_t       data_rdata,
  output lock_t       lock_wdata,
  input  lock_t       lock_rdata
);

  typedef enum logic [2:0] {
    st_idle,
    st_miss,
    st_pass,
    st_update,
    st_fence,
    st_writeback
  } state_t;

  // Front register. It holds the request while the arrays read its line.
  logic                 f_valid_q;
  logic                 f_fence_q;
  logic [31:0]          f_addr_q;
  logic [31:0]          f_wdata_q;
  logic [3:0]           f_wstrb_q;
  tag_t                 f_tag_q;
  index_t               f_index_q;
  logic [word_bits-1:0] f_word_q;

  // Back stage.
  state_t               state_q, state_d;
  logic [31:0]          addr_q, addr_d;
  logic [31:0]          wdata_q, wdata_d;
  logic [3:0]           wstrb_q, wstrb_d;
  tag_t                 tag_q, tag_d;
  index_t               index_q, index_d;
  logic [word_bits-1:0] word_q, word_d;
  logic [word_bits-1:0] cnt_q, cnt_d;
  line_t                line_q, line_d;
  logic                 fence_q, fence_d;

  logic in_window;
  logic tag_match;
  logic last_word;

  function automatic logic [31:0] merge_word(
    input logic [31:0] old_word,
    input logic [31:0] new_word,
    input logic [3:0]  strb
  );
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  assign in_window = (f_addr_q >= dtim_base_addr) && (f_addr_q < dtim_top_addr);
  assign tag_match = (tag_rdata == f_tag_q);
  assign last_word = (cnt_q == word_bits'(words_per_line - 1));

  always_ff @(posedge clk) begin
    if (!rst) begin
      f_valid_q <= 1'b0;
      state_q <= st_idle;
    end else begin
      f_valid_q <= req_valid;
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      f_fence_q <= req_fence;
      f_addr_q <= req_addr;
      f_wdata_q <= req_wdata;
      f_wstrb_q <= req_wstrb;
      f_tag_q <= req_addr[31 -: tag_bits];
      f_index_q <= req_addr[word_bits+2 +: line_depth];
      f_word_q <= req_addr[2 +: word_bits];
    end
    addr_q <= addr_d;
    wdata_q <= wdata_d;
    wstrb_q <= wstrb_d;
    tag_q <= tag_d;
    index_q <= index_d;
    word_q <= word_d;
    cnt_q <= cnt_d;
    line_q <= line_d;
    fence_q <= fence_d;
  end

  always_comb begin
    state_d = state_q;
    addr_d = addr_q;
    wdata_d = wdata_q;
    wstrb_d = wstrb_q;
    tag_d = tag_q;
    index_d = index_q;
    word_d = word_q;
    cnt_d = cnt_q;
    line_d = line_q;
    fence_d = fence_q;

    rsp_ready = 1'b0;
    rsp_rdata = '0;
    tag_wen = 1'b0;
    data_wen = 1'b0;
    lock_wen = 1'b0;
    line_waddr = index_q;
    tag_wdata = tag_q;
    data_wdata = line_q;
    lock_wdata = 1'b0;

    case (state_q)
      st_idle: begin
        if (f_valid_q) begin
          tag_d = f_tag_q;
          index_d = f_index_q;
          word_d = f_word_q;
          wdata_d = f_wdata_q;
          wstrb_d = f_wstrb_q;
          fence_d = f_fence_q;
          cnt_d = '0;
          if (f_fence_q) begin
            index_d = '0;
            state_d = st_fence;
          end else if (!in_window || (lock_rdata && !tag_match)) begin
            addr_d = f_addr_q;
            state_d = st_pass;
          end else if (!lock_rdata) begin
            addr_d = {f_addr_q[31:word_bits+2], {(word_bits + 2){1'b0}}};
            state_d = st_miss;
          end else if (|f_wstrb_q) begin
            // Write hit. The merged line goes back now and the response follows.
            line_d = data_rdata;
            line_d[f_word_q] = merge_word(data_rdata[f_word_q], f_wdata_q, f_wstrb_q);
            data_wen = 1'b1;
            data_wdata = line_d;
            line_waddr = f_index_q;
            state_d = st_update;
          end else begin
            rsp_ready = 1'b1;
            rsp_rdata = data_rdata[f_word_q];
          end
        end
      end

      st_miss: begin
        if (mem_ready) begin
          line_d[cnt_q] = mem_rdata;
          if (last_word) begin
            // A write miss lands its bytes in the line before it is stored.
            if (|wstrb_q) begin
              line_d[word_q] = merge_word(line_d[word_q], wdata_q, wstrb_q);
            end
            tag_wen = 1'b1;
            data_wen = 1'b1;
            lock_wen = 1'b1;
            data_wdata = line_d;
            lock_wdata = 1'b1;
            state_d = st_update;
          end else begin
            cnt_d = cnt_q + 1'b1;
            addr_d = addr_q + 32'd4;
          end
        end
      end

      st_pass: begin
        if (mem_ready) begin
          rsp_ready = 1'b1;
          rsp_rdata = mem_rdata;
          state_d = st_idle;
        end
      end

      st_update: begin
        rsp_ready = 1'b1;
        rsp_rdata = fence_q ? 32'd0 : line_q[word_q];
        state_d = st_idle;
      end

      st_fence: begin
        if (lock_rdata) begin
          line_d = data_rdata;
          addr_d = {tag_rdata, index_q, {(word_bits + 2){1'b0}}};
          cnt_d = '0;
          state_d = st_writeback;
        end else if (index_q == '1) begin
          state_d = st_update;
        end else begin
          index_d = index_q + 1'b1;
        end
      end

      st_writeback: begin
        if (mem_ready) begin
          if (last_word) begin
            lock_wen = 1'b1;
            if (index_q == '1) begin
              state_d = st_update;
            end else begin
              index_d = index_q + 1'b1;
              state_d = st_fence;
            end
          end else begin
            cnt_d = cnt_q + 1'b1;
            addr_d = addr_q + 32'd4;
          end
        end
      end

      default: begin
        state_d = st_idle;
      end
    endcase
  end

  // The arrays read the index that the back stage looks at next cycle.
  // A new request takes priority, and a fence starts its walk at line 0.
  always_comb begin
    if (req_valid) begin
      line_raddr = req_fence ? '0 : req_addr[word_bits+2 +: line_depth];
    end else begin
      line_raddr = index_d;
    end
  end

  assign mem_valid = (state_q == st_miss) || (state_q == st_pass) ||
                     (state_q == st_writeback);
  assign mem_addr = addr_q;
  assign mem_wdata = (state_q == st_writeback) ? line_q[cnt_q] : wdata_q;

  always_comb begin
    case (state_q)
      st_pass: mem_wstrb = wstrb_q;
      st_writeback: mem_wstrb = 4'hf;
      default: mem_wstrb = 4'h0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/dtim_pkg.sv
`default_nettype none

package dtim_pkg;

  // Line store geometry.
  // Every address in the window splits into tag, line index, word and byte.
  localparam int line_depth = 3;
  localparam int word_bits = 2;
  localparam int words_per_line = 2 ** word_bits;
  localparam int tag_bits = 32 - line_depth - word_bits - 2;

  // Requests from the base up to the top, top excluded, are held on chip.
  localparam logic [31:0] dtim_base_addr = 32'h0000_1000;
  localparam logic [31:0] dtim_top_addr = 32'h0000_2000;

  // Payloads of the three line-store arrays.
  typedef logic [tag_bits-1:0] tag_t;

  // Word 0 of a line sits in the low 32 bits.
  typedef logic [words_per_line-1:0][31:0] line_t;

  // Set once a line has been filled.
  // It is cleared only when a fence writes the line back.
  typedef logic lock_t;

  typedef logic [line_depth-1:0] index_t;

endpackage

`default_nettype wire

// File: verification/dtim_properties.sv
`default_nettype none

module dtim_properties (
  input logic        clk,
  input logic        rst,
  input logic        rsp_ready,
  input logic        mem_valid,
  input logic [31:0] mem_addr,
  input logic [3:0]  mem_wstrb,
  input logic        mem_ready,
  input logic [2:0]  ctrl_state
);
  timeunit 1ns;
  timeprecision 100ps;

  // Encoding of the line fill state in the controller.
  localparam logic [2:0] fill_state = 3'd1;

  int fail_count = 0;

  mem_hold: assert property (@(posedge clk) disable iff (!rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr))
    else begin
      fail_count++;
      $error("mem_valid or mem_addr changed while mem_ready was low");
    end

  rsp_pulse: assert property (@(posedge clk) disable iff (!rst)
    rsp_ready |=> !rsp_ready)
    else begin
      fail_count++;
      $error("rsp_ready was high for two cycles in a row");
    end

  // Fill reads must never carry byte strobes.
  fill_read: assert property (@(posedge clk) disable iff (!rst)
    (ctrl_state == fill_state) |-> (mem_wstrb == 4'h0))
    else begin
      fail_count++;
      $error("mem_wstrb was nonzero during a line fill");
    end

endmodule

bind dtim dtim_properties props (
  .clk        (clk),
  .rst        (rst),
  .rsp_ready  (rsp_ready),
  .mem_valid  (mem_valid),
  .mem_addr   (mem_addr),
  .mem_wstrb  (mem_wstrb),
  .mem_ready  (mem_ready),
  .ctrl_state (ctrl.state_q)
);

`default_nettype wire

// File: verification/dtim_stimulus.txt
# kind: 0 read, 1 read hit in one cycle, 2 write, 3 fence, 4 backing word, 5 read miss
# columns: kind address write_data strobes expected_data, all in hex
5 00001040 00000000 0 a5a51040
1 00001044 00000000 0 a5a51044
2 00001044 deadbeef 5 00000000
1 00001044 00000000 0 a5ad10ef
2 00000200 12345678 f 00000000
0 00000200 00000000 0 12345678
4 00000200 00000000 0 12345678
2 00000204 cafef00d 3 00000000
0 00000204 00000000 0 a5a5f00d
4 00000204 00000000 0 a5a5f00d
0 00001840 00000000 0 a5a51840
1 00001040 00000000 0 a5a51040
1 00001044 00000000 0 a5ad10ef
3 00000000 00000000 0 00000000
4 00001040 00000000 0 a5a51040
4 00001044 00000000 0 a5ad10ef
4 00001048 00000000 0 a5a51048
4 0000104c 00000000 0 a5a5104c
5 00001044 00000000 0 a5ad10ef
1 00001048 00000000 0 a5a51048
1 0000104c 00000000 0 a5a5104c
4 00001840 00000000 0 a5a51840

// File: verification/tb_dtim.sv
`default_nettype none

module tb_dtim;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int image_words = 4096;
  // About 24 operations at a worst case of 150 cycles each, rounded up.
  localparam int timeout_cycles = 4000;

  logic        clk = 1'b0;
  logic        rst;
  logic        req_valid;
  logic        req_fence;
  logic [31:0] req_addr;
  logic [31:0] req_wdata;
  logic [3:0]  req_wstrb;
  logic        rsp_ready;
  logic [31:0] rsp_rdata;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic        mem_ready;
  logic [31:0] mem_rdata;

  logic [31:0] image [0:image_words-1];
  logic [11:0] model_idx;
  int          seed = 50440;
  int          wait_left = 0;
  int          cycle_count = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          total_errors;
  int          fd;
  string       text;
  logic [3:0]  op_kind;
  logic [31:0] op_addr;
  logic [31:0] op_wdata;
  logic [3:0]  op_strb;
  logic [31:0] op_expect;

  dtim UUT (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_fence (req_fence),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_wstrb (req_wstrb),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Run stopped after %0d cycles before the stimulus was done.", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  // Backing memory. Each word is answered after 0 to 3 idle cycles.
  always @(posedge clk) begin
    mem_ready <= 1'b0;
    if (rst && mem_valid && !mem_ready) begin
      if (wait_left == 0) begin
        model_idx = mem_addr[13:2];
        for (int b = 0; b < 4; b++) begin
          if (mem_wstrb[b]) begin
            image[model_idx][8*b +: 8] = mem_wdata[8*b +: 8];
          end
        end
        mem_rdata <= image[model_idx];
        mem_ready <= 1'b1;
        wait_left = $unsigned($random(seed)) % 4;
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  // Latency counts cycles from the req_valid cycle to the rsp_ready cycle.
  task automatic request(input logic fence, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] strb, output int latency, output logic [31:0] rdata);
    @(posedge clk);
    req_valid <= 1'b1;
    req_fence <= fence;
    req_addr <= addr;
    req_wdata <= wdata;
    req_wstrb <= strb;
    @(posedge clk);
    req_valid <= 1'b0;
    req_fence <= 1'b0;
    latency = 1;
    @(negedge clk);
    while (!rsp_ready) begin
      @(negedge clk);
      latency++;
    end
    rdata = rsp_rdata;
  endtask

  task automatic run_op(input logic [3:0] kind, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] strb,
                        input logic [31:0] exp_data);
    int          latency;
    logic [31:0] rdata;
    int          errors_before;
    errors_before = errors;
    case (kind)
      4'h2: request(1'b0, addr, wdata, strb, latency, rdata);
      4'h3: begin
        request(1'b1, addr, 32'h0, 4'h0, latency, rdata);
        check_value("rsp_rdata", rdata, 32'h0);
      end
      4'h4: check_value("image", image[addr[13:2]], exp_data);
      default: begin
        request(1'b0, addr, 32'h0, 4'h0, latency, rdata);
        check_value("rsp_rdata", rdata, exp_data);
        if (kind == 4'h1) begin
          check_value("read_latency", latency, 1);
        end
        if (kind == 4'h5) begin
          check_value("read_missed", latency > 1, 1);
        end
      end
    endcase
    tests_run++;
    if (errors != errors_before) begin
      tests_failed++;
    end
    $display("test %0d kind %0h addr %h: %s", tests_run, kind, addr,
             (errors == errors_before) ? "pass" : "fail");
  endtask

  initial begin
    rst = 1'b0;
    req_valid = 1'b0;
    req_fence = 1'b0;
    req_addr = '0;
    req_wdata = '0;
    req_wstrb = '0;
    mem_ready = 1'b0;
    mem_rdata = '0;
    for (int i = 0; i < image_words; i++) begin
      image[i] = 32'(i * 4) ^ 32'hA5A5_0000;
    end
    fd = $fopen("verification/dtim_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/dtim_stimulus.txt for reading.");
      $display("Something failed");
      $finish;
    end else begin
      repeat (10) @(posedge clk);
      rst <= 1'b1;
      while (!$feof(fd)) begin
        text = "";
        void'($fgets(text, fd));
        if ($sscanf(text, "%h %h %h %h %h", op_kind, op_addr, op_wdata, op_strb,
                    op_expect) == 5) begin
          run_op(op_kind, op_addr, op_wdata, op_strb, op_expect);
        end
      end
      $fclose(fd);
      total_errors = errors + UUT.props.fail_count;
      $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
               tests_run, tests_failed, errors, UUT.props.fail_count);
      if (total_errors == 0 && tests_run > 0) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
